//--- filelist.f
logic/dmc_regs_pkg.sv
logic/dmc_types_pkg.sv
logic/dmc_fetch_fsm.sv
logic/dmc_rate_timer.sv
logic/dmc_sample_reader.sv
logic/dmc_output_unit.sv
logic/dmc_channel.sv
verif/dmc_tb_clock.sv
verif/dmc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= dmc_tb
RTL_TOP   ?= dmc_channel
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS := $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/dmc_tb.sv
// Testbench for the delta-modulation channel with memory model and level reference
`default_nettype none

module dmc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import dmc_regs_pkg::*;
	import dmc_types_pkg::*;

	localparam int P_FAST = int'(RATE_PERIOD[15]);
	localparam int P_SLOW = int'(RATE_PERIOD[0]);
	// 136 bytes at rate 15 and 2 at rate 0, 8 steps each, doubled, plus margin
	localparam int WATCHDOG_NS  = 10 * (2 * 8 * (136 * P_FAST + 2 * P_SLOW) + 20000);
	localparam int DRAIN_CYCLES = 24 * P_FAST + 50;  // Shifter, buffer, one silent cycle

	logic      aclk;
	logic      rst_n;
	logic [5:0] wstrobe;  // Indexed by the low address nibble
	reg_byte_t wdata;
	logic      dma_ack;
	reg_byte_t dma_data;
	logic      dma_req;
	addr_t     dma_addr;
	logic      irq;
	logic      status_active;
	level_t    level;

	addr_t     exp_addr[$];
	reg_byte_t fetched_data[$];
	logic      data_all_ones;
	int        acks = 0;
	int        error_count = 0;
	int        test_errors = 0;
	int        tests_run = 0;
	int        tests_failed = 0;

	dmc_tb_clock i_clock (
		.aclk  (aclk),
		.rst_n (rst_n)
	);

	dmc_channel i_dmc_channel (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.w4010         (wstrobe[0]),
		.w4011         (wstrobe[1]),
		.w4012         (wstrobe[2]),
		.w4013         (wstrobe[3]),
		.w4015         (wstrobe[5]),
		.wdata         (wdata),
		.dma_ack       (dma_ack),
		.dma_data      (dma_data),
		.dma_req       (dma_req),
		.dma_addr      (dma_addr),
		.irq           (irq),
		.status_active (status_active),
		.level         (level)
	);

	task automatic next_cycle();
		@(posedge aclk);
		#1;
	endtask

	task automatic write_reg(input logic [15:0] addr, input reg_byte_t data);
		wdata = data;
		wstrobe[addr[2:0]] = 1'b1;
		next_cycle();
		wstrobe = '0;
	endtask

	task automatic value_error(input string what, input int got, input int want);
		$display("** Error at %0d ns: %s, got %0h, expected %0h", $time, what, got, want);
		error_count++;
		test_errors++;
	endtask

	task automatic plain_error(input string what);
		$display("%s", what);
		error_count++;
		test_errors++;
	endtask

	// Expected fetch addresses, wrapping past the top of memory
	task automatic push_run(input addr_t start, input int count);
		addr_t a;
		a = start;
		repeat (count) begin
			exp_addr.push_back(a);
			a = (a == 16'hFFFF) ? ADDR_WRAP : a + 16'd1;
		end
	endtask

	task automatic wait_idle();
		while (status_active) begin
			next_cycle();
		end
	endtask

	task automatic finish_test(input string name);
		if (exp_addr.size() != 0) begin
			plain_error($sformatf("Test %s ended with %0d fetches missing", name, exp_addr.size()));
			exp_addr.delete();
		end
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, test_errors);
		end else begin
			$display("Test %s: ok", name);
		end
		test_errors = 0;
	endtask

	// Delta rule, LSB first, clamped at both ends of the 7-bit range
	function automatic level_t expect_level(input level_t start, input reg_byte_t bytes[$]);
		level_t lvl;
		lvl = start;
		foreach (bytes[i]) begin
			for (int b = 0; b < 8; b++) begin
				if (bytes[i][b] && lvl <= 7'd125) begin
					lvl = lvl + 7'd2;
				end else if (!bytes[i][b] && lvl >= 7'd2) begin
					lvl = lvl - 7'd2;
				end
			end
		end
		return lvl;
	endfunction

	// One byte at the given rate, level steps must be one period apart
	task automatic check_step_spacing(input rate_idx_t rate);
		level_t prev;
		int     cycle;
		int     last_change;
		int     changes;
		write_reg(16'h4011, 8'h00);
		write_reg(16'h4010, {4'h0, rate});
		write_reg(16'h4012, 8'h00);
		write_reg(16'h4013, 8'h00);
		push_run(ADDR_BASE, 1);
		write_reg(16'h4015, 8'h10);
		prev = level;
		cycle = 0;
		last_change = 0;
		changes = 0;
		while (changes < 8) begin
			next_cycle();
			cycle++;
			if (level != prev) begin
				if (level != prev + 7'd2) begin
					value_error("level step", int'(level), int'(prev + 7'd2));
				end
				if (changes > 0 && cycle - last_change != int'(RATE_PERIOD[rate])) begin
					value_error("cycles between steps", cycle - last_change,
						int'(RATE_PERIOD[rate]));
				end
				last_change = cycle;
				changes++;
				prev = level;
			end
		end
	endtask

	// Memory answers each request after 0 to 5 cycles
	initial begin : memory_model
		int delay;
		dma_ack = 1'b0;
		dma_data = '0;
		void'($urandom(32'h9fb51c7f));
		forever begin
			next_cycle();
			if (dma_req) begin
				delay = int'($urandom % 6);
				repeat (delay) next_cycle();
				dma_data = data_all_ones ? 8'hFF : (dma_addr[7:0] ^ dma_addr[15:8]);
				dma_ack = 1'b1;
				next_cycle();
				dma_ack = 1'b0;
			end
		end
	end

	// Ack and address are both stable mid-cycle
	always @(negedge aclk) begin : compare_fetch
		addr_t want;
		if (dma_ack) begin
			acks++;
			fetched_data.push_back(dma_data);
			if (exp_addr.size() == 0) begin
				plain_error($sformatf("Unexpected fetch from address %04h", dma_addr));
			end else begin
				want = exp_addr.pop_front();
				if (dma_addr != want) begin
					value_error("fetch address", int'(dma_addr), int'(want));
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		level_t start_level;
		level_t want_level;
		int     base;
		int     stray;
		wstrobe = '0;
		wdata = '0;
		data_all_ones = 1'b0;
		wait (rst_n);
		next_cycle();

		write_reg(16'h4010, 8'h0F);  // Rate 15, no loop, no IRQ
		write_reg(16'h4012, 8'h10);
		write_reg(16'h4013, 8'h01);  // 17 bytes
		push_run(ADDR_BASE + 16'h0400, 17);
		write_reg(16'h4015, 8'h10);
		wait_idle();
		stray = 0;
		repeat (20) begin
			next_cycle();
			if (dma_req) begin
				stray++;
			end
		end
		if (stray != 0) begin
			plain_error("Request still raised after the last byte was fetched");
		end
		finish_test("address sequence");

		write_reg(16'h4012, 8'hFF);  // Starts at $FFC0
		write_reg(16'h4013, 8'h04);  // 65 bytes
		push_run(ADDR_BASE + 16'h3FC0, 65);
		write_reg(16'h4015, 8'h10);
		wait_idle();
		finish_test("wrap");

		write_reg(16'h4010, 8'hCF);  // Loop with IRQ enable
		write_reg(16'h4012, 8'h20);
		write_reg(16'h4013, 8'h01);
		push_run(ADDR_BASE + 16'h0800, 17);
		push_run(ADDR_BASE + 16'h0800, 17);
		base = acks;
		write_reg(16'h4015, 8'h10);
		stray = 0;
		while (acks - base < 18) begin
			next_cycle();
			if (!status_active || irq) begin
				stray++;
			end
		end
		if (stray != 0) begin
			plain_error("Looped sample dropped status or raised irq at the restart");
		end
		write_reg(16'h4010, 8'h0F);  // Second pass ends the sample
		wait_idle();
		finish_test("loop");

		write_reg(16'h4010, 8'h8F);
		write_reg(16'h4012, 8'h00);
		write_reg(16'h4013, 8'h00);  // Single byte
		push_run(ADDR_BASE, 1);
		write_reg(16'h4015, 8'h10);
		wait_idle();
		if (!irq) begin
			value_error("irq after last byte", 0, 1);
		end
		write_reg(16'h4015, 8'h00);
		if (irq) begin
			value_error("irq after $4015 write", 1, 0);
		end
		push_run(ADDR_BASE, 1);
		write_reg(16'h4015, 8'h10);
		wait_idle();
		if (!irq) begin
			value_error("irq after second run", 0, 1);
		end
		write_reg(16'h4010, 8'h0F);
		next_cycle();  // Flag clears one cycle after the enable drops
		if (irq) begin
			value_error("irq after $4010 IRQ disable", 1, 0);
		end
		finish_test("irq");

		repeat (DRAIN_CYCLES) next_cycle();
		start_level = 7'h40;
		write_reg(16'h4011, {1'b0, start_level});
		if (level != start_level) begin
			value_error("level after $4011 write", int'(level), int'(start_level));
		end
		fetched_data.delete();
		write_reg(16'h4012, 8'h9A);  // Mixed bit patterns from $E680
		write_reg(16'h4013, 8'h01);
		push_run(ADDR_BASE + 16'h2680, 17);
		write_reg(16'h4015, 8'h10);
		wait_idle();
		repeat (DRAIN_CYCLES) next_cycle();
		want_level = expect_level(start_level, fetched_data);
		if (level != want_level) begin
			value_error("final level", int'(level), int'(want_level));
		end
		finish_test("output level");

		data_all_ones = 1'b1;
		check_step_spacing(4'd15);
		check_step_spacing(4'd0);
		finish_test("rate period");

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/dmc_tb_clock.sv
// Testbench clock and synchronous reset source for the delta-modulation channel
`default_nettype none

module dmc_tb_clock (
	output logic aclk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 5;   // 10 ns clock
	localparam int RESET_CYCLES = 16;

	initial begin
		aclk = 1'b0;
		forever #HALF_PERIOD aclk = ~aclk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge aclk);
		#1 rst_n = 1'b1;  // Released just after an edge
	end

endmodule

`default_nettype wire

//--- logic/dmc_channel.sv
// Delta-modulation sample channel top with the $4010 control register
`default_nettype none

module dmc_channel (
	input  logic                    aclk,
	input  logic                    rst_n,
	input  logic                    w4010,
	input  logic                    w4011,
	input  logic                    w4012,
	input  logic                    w4013,
	input  logic                    w4015,
	input  dmc_regs_pkg::reg_byte_t wdata,
	input  logic                    dma_ack,
	input  dmc_regs_pkg::reg_byte_t dma_data,
	output logic                    dma_req,
	output dmc_types_pkg::addr_t    dma_addr,
	output logic                    irq,
	output logic                    status_active,
	output dmc_regs_pkg::level_t    level
);

	import dmc_regs_pkg::*;

	rate_idx_t rate;
	logic      loop_en;
	logic      irq_en;
	logic      byte_commit;
	logic      buffer_empty;
	logic      step_tick;

	// $4010 rate, loop and IRQ enable
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			rate    <= '0;
			loop_en <= 1'b0;
			irq_en  <= 1'b0;
		end else if (w4010) begin
			rate    <= wdata[3:0];
			loop_en <= wdata[CTRL_LOOP_BIT];
			irq_en  <= wdata[CTRL_IRQ_EN_BIT];
		end
	end

	dmc_fetch_fsm i_fetch_fsm (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.buffer_empty  (buffer_empty),
		.status_active (status_active),
		.dma_ack       (dma_ack),
		.dma_req       (dma_req),
		.byte_commit   (byte_commit)
	);

	dmc_rate_timer i_rate_timer (
		.aclk      (aclk),
		.rst_n     (rst_n),
		.rate      (rate),
		.step_tick (step_tick)
	);

	dmc_sample_reader i_sample_reader (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.w4012         (w4012),
		.w4013         (w4013),
		.w4015         (w4015),
		.wdata         (wdata),
		.loop_en       (loop_en),
		.irq_en        (irq_en),
		.byte_commit   (byte_commit),
		.dma_addr      (dma_addr),
		.status_active (status_active),
		.irq           (irq)
	);

	dmc_output_unit i_output_unit (
		.aclk         (aclk),
		.rst_n        (rst_n),
		.w4011        (w4011),
		.wdata        (wdata),
		.byte_commit  (byte_commit),
		.dma_data     (dma_data),
		.step_tick    (step_tick),
		.buffer_empty (buffer_empty),
		.level        (level)
	);

endmodule

`default_nettype wire

//--- logic/dmc_output_unit.sv
// Sample buffer, shift register, bit counter, silence flag and delta level counter
`default_nettype none

module dmc_output_unit (
	input  logic                    aclk,
	input  logic                    rst_n,
	input  logic                    w4011,
	input  dmc_regs_pkg::reg_byte_t wdata,
	input  logic                    byte_commit,
	input  dmc_regs_pkg::reg_byte_t dma_data,
	input  logic                    step_tick,
	output logic                    buffer_empty,
	output dmc_regs_pkg::level_t    level
);

	import dmc_regs_pkg::*;
	import dmc_types_pkg::*;

	reg_byte_t sample_buf;
	reg_byte_t shift_reg;
	logic      buf_full;
	bitcnt_t   bit_cnt;
	logic      silent;
	level_t    level_q;
	logic      cycle_end;
	logic      out_bit;

	// Last bit of the current 8-bit cycle is being played
	assign cycle_end = step_tick && (bit_cnt == '0);
	assign out_bit   = shift_reg[0];

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			buf_full <= 1'b0;
			bit_cnt  <= '0;
			silent   <= 1'b1;
		end else begin
			if (byte_commit) begin
				buf_full <= 1'b1;
			end
			if (step_tick) begin
				bit_cnt <= bit_cnt - bitcnt_t'(1);  // Wraps to 7 at cycle end
			end
			if (cycle_end) begin
				silent <= !buf_full;
				if (buf_full) begin
					buf_full <= 1'b0;  // Byte moves to the shifter
				end
			end
		end
	end

	// Data path
	always_ff @(posedge aclk) begin
		if (byte_commit) begin
			sample_buf <= dma_data;
		end
		if (cycle_end && buf_full) begin
			shift_reg <= sample_buf;
		end else if (step_tick) begin
			shift_reg <= {1'b0, shift_reg[7:1]};  // LSB first
		end
	end

	// Delta counter, clamped at both ends
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			level_q <= '0;
		end else if (w4011) begin
			level_q <= level_t'(wdata[6:0]);  // Direct load wins over a step
		end else if (step_tick && !silent) begin
			if (out_bit && (level_q <= LEVEL_MAX_STEP_UP)) begin
				level_q <= level_q + level_t'(2);
			end else if (!out_bit && (level_q >= level_t'(2))) begin
				level_q <= level_q - level_t'(2);
			end
		end
	end

	assign buffer_empty = !buf_full;
	assign level        = level_q;

endmodule

`default_nettype wire

//--- logic/dmc_sample_reader.sv
// Sample address and bytes-remaining counters with loop restart and IRQ flag
`default_nettype none

module dmc_sample_reader (
	input  logic                    aclk,
	input  logic                    rst_n,
	input  logic                    w4012,
	input  logic                    w4013,
	input  logic                    w4015,
	input  dmc_regs_pkg::reg_byte_t wdata,
	input  logic                    loop_en,
	input  logic                    irq_en,
	input  logic                    byte_commit,
	output dmc_types_pkg::addr_t    dma_addr,
	output logic                    status_active,
	output logic                    irq
);

	import dmc_regs_pkg::*;
	import dmc_types_pkg::*;

	reg_byte_t start_reg;  // $4012
	reg_byte_t len_reg;    // $4013
	addr_t     addr_cnt;
	len_t      remain;
	logic      irq_flag;
	addr_t     start_addr;
	len_t      start_len;
	logic      last_byte;

	assign start_addr = ADDR_BASE + addr_t'(start_reg) * addr_t'(ADDR_UNIT);
	assign start_len  = len_t'(len_reg) * len_t'(LEN_UNIT) + len_t'(1);
	assign last_byte  = (remain == len_t'(1));

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			start_reg <= '0;
			len_reg   <= '0;
			addr_cnt  <= ADDR_BASE;
			remain    <= '0;
			irq_flag  <= 1'b0;
		end else begin
			if (w4012) begin
				start_reg <= wdata;
			end
			if (w4013) begin
				len_reg <= wdata;
			end
			if (byte_commit) begin
				addr_cnt <= (addr_cnt == 16'hFFFF) ? ADDR_WRAP : addr_cnt + addr_t'(1);
				remain   <= remain - len_t'(1);
				if (last_byte && loop_en) begin  // Loop back to the start
					addr_cnt <= start_addr;
					remain   <= start_len;
				end else if (last_byte && irq_en) begin
					irq_flag <= 1'b1;
				end
			end
			if (w4015) begin
				irq_flag <= 1'b0;
				if (!wdata[STATUS_ENABLE_BIT]) begin
					remain <= '0;
				end else if (remain == '0) begin  // Restart only when idle
					addr_cnt <= start_addr;
					remain   <= start_len;
				end
			end
			if (!irq_en) begin
				irq_flag <= 1'b0;  // IRQ enable low holds the flag clear
			end
		end
	end

	assign dma_addr      = addr_cnt;
	assign status_active = (remain != '0);
	assign irq           = irq_flag;

	// Fetch sequencer only commits while bytes are left
	a_commit_active: assert property (
		@(posedge aclk) disable iff (!rst_n)
		byte_commit |-> (remain != '0)
	) else $error("byte_commit with no bytes remaining");

endmodule

`default_nettype wire

//--- logic/dmc_rate_timer.sv
// Output step timer, a down-counter reloaded from the rate period table
`default_nettype none

module dmc_rate_timer (
	input  logic                    aclk,
	input  logic                    rst_n,
	input  dmc_regs_pkg::rate_idx_t rate,
	output logic                    step_tick
);

	import dmc_types_pkg::*;

	period_t count;
	period_t reload;

	// Tick cycle plus reload value gives one full period
	assign reload = RATE_PERIOD[rate] - period_t'(1);

	assign step_tick = (count == '0);

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (step_tick) begin
			count <= reload;  // Rate change lands here
		end else begin
			count <= count - period_t'(1);
		end
	end

endmodule

`default_nettype wire

//--- logic/dmc_fetch_fsm.sv
// Sample fetch sequencer that raises memory requests and commits returned bytes
`default_nettype none

module dmc_fetch_fsm (
	input  logic aclk,
	input  logic rst_n,
	input  logic buffer_empty,
	input  logic status_active,
	input  logic dma_ack,
	output logic dma_req,
	output logic byte_commit
);

	import dmc_types_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			FETCH_IDLE: begin
				if (buffer_empty && status_active) begin  // Byte needed and one left
					state_next = FETCH_REQUEST;
				end
			end
			FETCH_REQUEST: begin
				if (dma_ack) begin
					state_next = FETCH_HOLDOFF;
				end
			end
			FETCH_HOLDOFF: begin
				state_next = FETCH_IDLE;  // Single settle cycle
			end
			default: begin
				state_next = FETCH_IDLE;
			end
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state <= FETCH_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign dma_req     = (state == FETCH_REQUEST);
	assign byte_commit = (state == FETCH_REQUEST) && dma_ack;  // Same cycle as ack

	// Memory side may only answer a pending request
	a_ack_in_request: assert property (
		@(posedge aclk) disable iff (!rst_n)
		dma_ack |-> (state == FETCH_REQUEST)
	) else $error("dma_ack without a pending request");

endmodule

`default_nettype wire

//--- logic/dmc_types_pkg.sv
// Delta-modulation channel internal widths, fetch states and address constants
`default_nettype none

package dmc_types_pkg;

	typedef logic [15:0] addr_t;  // Sample fetch address
	typedef logic [11:0] len_t;   // Bytes still to fetch
	typedef logic [8:0]  period_t;  // Rate timer count
	typedef logic [2:0]  bitcnt_t;  // Bits left in the shift register

	typedef enum logic [1:0] {
		FETCH_IDLE    = 2'd0,  // Nothing pending
		FETCH_REQUEST = 2'd1,  // Request up, waiting for ack
		FETCH_HOLDOFF = 2'd2   // Buffer status settles after a commit
	} fetch_state_t;

	// Output step period in APU cycles, one entry per rate index
	localparam period_t RATE_PERIOD [16] = '{
		9'd214, 9'd190, 9'd170, 9'd160,
		9'd143, 9'd127, 9'd113, 9'd107,
		9'd95,  9'd80,  9'd71,  9'd64,
		9'd53,  9'd42,  9'd36,  9'd27
	};

	localparam addr_t ADDR_BASE = 16'hC000;  // Address of $4012 = 0
	localparam addr_t ADDR_WRAP = 16'h8000;  // Follows 16'hFFFF

	localparam int ADDR_UNIT = 64;  // Address step per $4012 unit
	localparam int LEN_UNIT  = 16;  // Length step per $4013 unit

endpackage

`default_nettype wire

//--- logic/dmc_regs_pkg.sv
// Delta-modulation channel register fields and register-facing vector types
`default_nettype none

package dmc_regs_pkg;

	// Byte written by the CPU to a channel register
	typedef logic [7:0] reg_byte_t;

	// Rate select, indexes the period table
	typedef logic [3:0] rate_idx_t;

	// Output level fed to the DAC
	typedef logic [6:0] level_t;

	// $4010 fields
	localparam int CTRL_IRQ_EN_BIT = 7;
	localparam int CTRL_LOOP_BIT   = 6;

	// $4015 field for this channel
	localparam int STATUS_ENABLE_BIT = 4;

	// Highest level that may still rise by 2
	localparam level_t LEVEL_MAX_STEP_UP = 7'd125;

endpackage

`default_nettype wire
